// ==== ex_isa_pkg.sv ====
`default_nettype none

package ex_isa_pkg;

    localparam int xlen = 64;

    // ====================
    // ALU operations
    // ====================
    typedef enum logic [4:0] {
        add      = 5'd0,
        sub      = 5'd1,
        sll      = 5'd2,
        slt      = 5'd3,
        sltu     = 5'd4,
        xor_op   = 5'd5,
        srl      = 5'd6,
        sra      = 5'd7,
        or_op    = 5'd8,
        and_op   = 5'd9,
        lui_pass = 5'd10,
        addw     = 5'd16,
        subw     = 5'd17,
        sllw     = 5'd18,
        srlw     = 5'd22,
        sraw     = 5'd23
    } alu_op_e;

    // Conditional branches follow funct3 in the low bits
    typedef enum logic [3:0] {
        none = 4'd15,
        beq  = 4'd0,
        bne  = 4'd1,
        blt  = 4'd4,
        bge  = 4'd5,
        bltu = 4'd6,
        bgeu = 4'd7,
        jal  = 4'd8,
        jalr = 4'd9
    } branch_op_e;

    typedef enum logic [1:0] {
        reg_b      = 2'd0,
        const_four = 2'd1,
        imm        = 2'd2,
        csr_val    = 2'd3
    } src_b_e;

    // Load/store width, same numbering as funct3
    typedef enum logic [2:0] {
        mem_byte   = 3'd0,
        mem_half   = 3'd1,
        mem_word   = 3'd2,
        mem_dword  = 3'd3,
        mem_byte_u = 3'd4,
        mem_half_u = 3'd5,
        mem_word_u = 3'd6
    } mem_width_e;

endpackage

`default_nettype wire

// ==== ex_bus_pkg.sv ====
`default_nettype none

package ex_bus_pkg;

    import ex_isa_pkg::*;

    // ====================
    // Decode to execute
    // ====================
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [31:0]     imm;
        logic [xlen-1:0] csr_val;
        logic            src_a_pc;
        src_b_e          src_b;
        alu_op_e         alu_op;
        branch_op_e      branch_op;
        logic            mem_rd;
        logic            mem_wr;
        mem_width_e      mem_width;
        logic [4:0]      rd;
        logic            reg_wr;
        logic            csr_op;
        logic [11:0]     csr_addr;
        logic            ecall;
        logic            mret;
        logic            error;
    } ex_req_t;

    // ====================
    // Execute to memory
    // ====================
    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] rs2_val;
        logic            mem_rd;
        logic            mem_wr;
        mem_width_e      mem_width;
        logic [4:0]      rd;
        logic            reg_wr;
        logic            csr_op;
        logic [11:0]     csr_addr;
        logic            ecall;
        logic            mret;
        logic            error;
        logic            misaligned;
    } ex_rsp_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } ex_redirect_t;

endpackage

`default_nettype wire

// ==== ex_issue_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_issue_reg
    import ex_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    block,
    input  logic    valid_in,
    input  ex_req_t req_in,
    output ex_req_t req,
    output logic    held_valid
);

    logic    valid_q;
    ex_req_t req_q;

    // ====================
    // Valid bit
    // ====================

    // Holds its value while the stage is blocked
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!block) begin
            valid_q <= valid_in;
        end
    end

    // ====================
    // Payload
    // ====================

    always_ff @(posedge clk) begin
        if (!block) begin
            req_q <= req_in;
        end
    end

    assign req        = req_q;
    assign held_valid = valid_q;

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  ex_req_t         req,
    output logic [xlen-1:0] alu_result
);

    function automatic logic [xlen-1:0] sext32(input logic [31:0] v);
        return {{(xlen - 32){v[31]}}, v};
    endfunction

    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [5:0]      shamt;
    logic [4:0]      shamt_w;

    logic [31:0] addw_res;
    logic [31:0] subw_res;
    logic [31:0] sllw_res;
    logic [31:0] srlw_res;
    logic [31:0] sraw_res;

    logic lt_s;
    logic lt_u;

    // ====================
    // Operand selection
    // ====================

    assign imm_ext = sext32(req.imm);
    assign op_a    = req.src_a_pc ? req.pc : req.rs1_val;

    always_comb begin
        case (req.src_b)
            reg_b:      op_b = req.rs2_val;
            const_four: op_b = 64'd4;
            imm:        op_b = imm_ext;
            csr_val:    op_b = req.csr_val;
            default:    op_b = req.rs2_val;
        endcase
    end

    assign shamt   = op_b[5:0];
    assign shamt_w = op_b[4:0];

    // ====================
    // 32-bit W variants
    // ====================

    assign addw_res = op_a[31:0] + op_b[31:0];
    assign subw_res = op_a[31:0] - op_b[31:0];
    assign sllw_res = op_a[31:0] << shamt_w;
    assign srlw_res = op_a[31:0] >> shamt_w;
    assign sraw_res = $signed(op_a[31:0]) >>> shamt_w;

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // ====================
    // Result select
    // ====================

    always_comb begin
        case (req.alu_op)
            add:      alu_result = op_a + op_b;
            sub:      alu_result = op_a - op_b;
            sll:      alu_result = op_a << shamt;
            slt:      alu_result = {{(xlen - 1){1'b0}}, lt_s};
            sltu:     alu_result = {{(xlen - 1){1'b0}}, lt_u};
            xor_op:   alu_result = op_a ^ op_b;
            srl:      alu_result = op_a >> shamt;
            sra:      alu_result = $signed(op_a) >>> shamt;
            or_op:    alu_result = op_a | op_b;
            and_op:   alu_result = op_a & op_b;
            // Decode already placed the upper immediate
            lui_pass: alu_result = op_b;
            addw:     alu_result = sext32(addw_res);
            subw:     alu_result = sext32(subw_res);
            sllw:     alu_result = sext32(sllw_res);
            srlw:     alu_result = sext32(srlw_res);
            sraw:     alu_result = sext32(sraw_res);
            default:  alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== ex_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  ex_req_t      req,
    output ex_redirect_t br
);

    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] jalr_sum;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    // ====================
    // Compare
    // ====================

    // Own comparator so the ALU stays off the branch path
    assign eq   = req.rs1_val == req.rs2_val;
    assign lt_s = $signed(req.rs1_val) < $signed(req.rs2_val);
    assign lt_u = req.rs1_val < req.rs2_val;

    always_comb begin
        case (req.branch_op)
            beq:     taken = eq;
            bne:     taken = !eq;
            blt:     taken = lt_s;
            bge:     taken = !lt_s;
            bltu:    taken = lt_u;
            bgeu:    taken = !lt_u;
            jal:     taken = 1'b1;
            jalr:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // ====================
    // Target
    // ====================

    assign imm_ext   = {{(xlen - 32){req.imm[31]}}, req.imm};
    assign pc_target = req.pc + imm_ext;
    assign jalr_sum  = req.rs1_val + imm_ext;

    assign br.taken  = taken;
    assign br.target = (req.branch_op == jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc_target;

endmodule

`default_nettype wire

// ==== ex_commit_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_commit_merge
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  ex_req_t         req,
    input  logic            held_valid,
    input  logic            kill,
    input  logic [xlen-1:0] alu_result,
    input  ex_redirect_t    br,
    output ex_rsp_t         rsp,
    output logic            rsp_valid,
    output ex_redirect_t    redirect
);

    logic misaligned;
    logic br_go;

    // Interrupt pending masks the whole stage output
    assign rsp_valid = held_valid && !kill;

    // Trap is raised later in writeback
    assign misaligned = br.taken && (br.target[1:0] != 2'b00);
    assign br_go      = br.taken && !misaligned;

    // ====================
    // Response
    // ====================

    assign rsp.result     = alu_result;
    assign rsp.rs2_val    = req.rs2_val;
    assign rsp.mem_rd     = req.mem_rd;
    assign rsp.mem_wr     = req.mem_wr;
    assign rsp.mem_width  = req.mem_width;
    assign rsp.rd         = req.rd;
    assign rsp.reg_wr     = req.reg_wr;
    assign rsp.csr_op     = req.csr_op;
    assign rsp.csr_addr   = req.csr_addr;
    assign rsp.ecall      = req.ecall;
    assign rsp.mret       = req.mret;
    assign rsp.error      = req.error;
    assign rsp.misaligned = misaligned;

    // ====================
    // Redirect
    // ====================

    // CSR access refetches from the next instruction
    assign redirect.taken  = rsp_valid && (br_go || req.csr_op);
    assign redirect.target = br_go ? br.target : req.pc + 64'd4;

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         block,
    input  logic         valid_in,
    input  logic         kill,
    input  ex_req_t      req_in,
    output ex_rsp_t      rsp,
    output logic         rsp_valid,
    output ex_redirect_t redirect
);

    ex_req_t         req;
    logic            held_valid;
    logic [xlen-1:0] alu_result;
    ex_redirect_t    br;

    ex_issue_reg i_issue_reg (
        .clk        (clk),
        .rst        (rst),
        .block      (block),
        .valid_in   (valid_in),
        .req_in     (req_in),
        .req        (req),
        .held_valid (held_valid)
    );

    // ALU and branch unit run side by side on the held request
    ex_alu i_alu (
        .req        (req),
        .alu_result (alu_result)
    );

    ex_branch_unit i_branch_unit (
        .req (req),
        .br  (br)
    );

    ex_commit_merge i_commit_merge (
        .req        (req),
        .held_valid (held_valid),
        .kill       (kill),
        .alu_result (alu_result),
        .br         (br),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .redirect   (redirect)
    );

endmodule

`default_nettype wire

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
();

    localparam logic [xlen-1:0] pc_base  = 64'h0000_0000_8000_0100;
    localparam logic [xlen-1:0] all_ones = '1;

    typedef struct packed {
        ex_req_t         req;
        logic            valid;
        logic            block;
        logic            kill;
        logic [xlen-1:0] result;
        ex_redirect_t    redirect;
        logic            misaligned;
    } row_t;

    logic         clk;
    logic         rst;
    logic         block;
    logic         valid_in;
    logic         kill;
    ex_req_t      req_in;
    ex_rsp_t      rsp;
    logic         rsp_valid;
    ex_redirect_t redirect;

    row_t        rows[$];
    logic [15:0] lfsr;
    logic        table_ready;

    ex_stage i_ex_stage (
        .clk       (clk),
        .rst       (rst),
        .block     (block),
        .valid_in  (valid_in),
        .kill      (kill),
        .req_in    (req_in),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .redirect  (redirect)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic fail_now(input string line);
        $display("sim failed");
        $display("%s", line);
        $fatal(1);
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s rsp_valid is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_redirect(input ex_redirect_t got, input ex_redirect_t exp,
                                  input string what);
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
            fail_now($sformatf("mismatch at %0t: %s redirect %b %h, expected %b %h",
                $time, what, got.taken, got.target, exp.taken, exp.target));
        end
    endtask

    task automatic check_rsp(input ex_rsp_t got, input ex_rsp_t exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s result %h misaligned %b, expected %h %b",
                $time, what, got.result, got.misaligned, exp.result, exp.misaligned));
        end
    endtask

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [xlen-1:0] rand_bits(input int n);
        logic [xlen-1:0] v;
        logic            fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[xlen-2:0], fb};
        end
        return v;
    endfunction

    // Reference ALU model
    function automatic logic [xlen-1:0] model_alu(input ex_req_t r);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [31:0]     w;
        a = r.src_a_pc ? r.pc : r.rs1_val;
        case (r.src_b)
            const_four: b = 64'd4;
            imm:        b = {{32{r.imm[31]}}, r.imm};
            csr_val:    b = r.csr_val;
            default:    b = r.rs2_val;
        endcase
        case (r.alu_op)
            add:      return a + b;
            sub:      return a - b;
            sll:      return a << b[5:0];
            slt:      return {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            sltu:     return {{(xlen - 1){1'b0}}, a < b};
            xor_op:   return a ^ b;
            srl:      return a >> b[5:0];
            sra:      return $signed(a) >>> b[5:0];
            or_op:    return a | b;
            and_op:   return a & b;
            lui_pass: return b;
            addw:     w = a[31:0] + b[31:0];
            subw:     w = a[31:0] - b[31:0];
            sllw:     w = a[31:0] << b[4:0];
            srlw:     w = a[31:0] >> b[4:0];
            sraw:     w = $signed(a[31:0]) >>> b[4:0];
            default:  return '0;
        endcase
        return {{32{w[31]}}, w};
    endfunction

    // ====================
    // Stimulus table
    // ====================

    function automatic ex_req_t make_req(input alu_op_e op, input src_b_e sb,
                                         input branch_op_e bop, input logic [xlen-1:0] a,
                                         input logic [xlen-1:0] b, input logic [31:0] im);
        ex_req_t r;
        r           = '0;
        r.pc        = pc_base;
        r.rs1_val   = a;
        r.rs2_val   = b;
        r.imm       = im;
        r.csr_val   = {a[31:0], b[63:32]};
        r.alu_op    = op;
        r.src_b     = sb;
        r.branch_op = bop;
        r.rd        = a[4:0] | 5'd1;
        // Pass-through fields take spare operand bits
        r.reg_wr    = ~b[4];
        r.mem_rd    = b[0];
        r.mem_wr    = b[1];
        r.mem_width = mem_width_e'({1'b0, b[3:2]});
        r.ecall     = a[5];
        r.mret      = a[6];
        r.error     = a[7];
        return r;
    endfunction

    task automatic append_row(input ex_req_t r, input logic vld, input logic blk,
                              input logic kl, input logic [xlen-1:0] res, input logic tk,
                              input logic [xlen-1:0] tgt, input logic mis);
        row_t e;
        e.req             = r;
        e.valid           = vld;
        e.block           = blk;
        e.kill            = kl;
        e.result          = res;
        e.redirect.taken  = tk;
        e.redirect.target = tgt;
        e.misaligned      = mis;
        rows.push_back(e);
    endtask

    // Link value pc + 4 comes out of the ALU
    task automatic branch_row(input branch_op_e bop, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b, input logic [31:0] im, input logic tk,
                              input logic [xlen-1:0] tgt, input logic mis, input logic kl);
        ex_req_t r;
        r          = make_req(add, const_four, bop, a, b, im);
        r.src_a_pc = 1'b1;
        append_row(r, 1'b1, 1'b0, kl, pc_base + 64'd4, tk, tgt, mis);
    endtask

    task automatic build_table();
        alu_op_e         ops[16];
        ex_req_t         r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [31:0]     im;
        ops = '{add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, lui_pass,
                addw, subw, sllw, srlw, sraw};
        for (int k = 0; k < 16; k++) begin
            a          = rand_bits(64);
            b          = rand_bits(64);
            im         = 32'(rand_bits(32));
            r          = make_req(ops[k], src_b_e'(2'(k)), none, a, b, im);
            r.src_a_pc = (k % 3 == 2);
            append_row(r, 1'b1, 1'b0, 1'b0, model_alu(r), 1'b0, 64'd0, 1'b0);
        end
        branch_row(beq, 64'd5, 64'd5, 32'h40, 1'b1, pc_base + 64'h40, 1'b0, 1'b0);
        branch_row(beq, 64'd5, 64'd6, 32'h40, 1'b0, 64'd0, 1'b0, 1'b0);
        branch_row(bne, 64'd5, 64'd6, 32'hffff_fff0, 1'b1, pc_base - 64'h10, 1'b0, 1'b0);
        branch_row(bne, 64'd7, 64'd7, 32'hffff_fff0, 1'b0, 64'd0, 1'b0, 1'b0);
        branch_row(blt, all_ones, 64'd1, 32'h20, 1'b1, pc_base + 64'h20, 1'b0, 1'b0);
        branch_row(blt, 64'd1, all_ones, 32'h20, 1'b0, 64'd0, 1'b0, 1'b0);
        branch_row(bge, 64'd1, all_ones, 32'h20, 1'b1, pc_base + 64'h20, 1'b0, 1'b0);
        branch_row(bge, all_ones, 64'd1, 32'h20, 1'b0, 64'd0, 1'b0, 1'b0);
        branch_row(bltu, 64'd1, all_ones, 32'h20, 1'b1, pc_base + 64'h20, 1'b0, 1'b0);
        branch_row(bltu, all_ones, 64'd1, 32'h20, 1'b0, 64'd0, 1'b0, 1'b0);
        branch_row(bgeu, all_ones, 64'd1, 32'h20, 1'b1, pc_base + 64'h20, 1'b0, 1'b0);
        branch_row(bgeu, 64'd1, all_ones, 32'h20, 1'b0, 64'd0, 1'b0, 1'b0);
        branch_row(jal, 64'd0, 64'd0, 32'h800, 1'b1, pc_base + 64'h800, 1'b0, 1'b0);
        branch_row(jalr, 64'h9000_0011, 64'd0, 32'h4, 1'b1, 64'h9000_0014, 1'b0, 1'b0);
        // Stalled cycles keep showing the jalr
        for (int k = 0; k < 3; k++) begin
            r = make_req(sub, reg_b, jal, 64'(k), 64'd3, 32'h1000);
            append_row(r, 1'b0, 1'b1, 1'b0, 64'd0, 1'b0, 64'd0, 1'b0);
        end
        branch_row(jal, 64'd0, 64'd0, 32'h22, 1'b0, 64'd0, 1'b1, 1'b0);
        branch_row(jal, 64'd0, 64'd0, 32'h100, 1'b1, pc_base + 64'h100, 1'b0, 1'b1);
        r          = make_req(or_op, csr_val, none, rand_bits(64), 64'd0, 32'd0);
        r.csr_op   = 1'b1;
        r.csr_addr = 12'h300;
        append_row(r, 1'b1, 1'b0, 1'b0, model_alu(r), 1'b1, pc_base + 64'd4, 1'b0);
        append_row(r, 1'b0, 1'b0, 1'b0, 64'd0, 1'b0, 64'd0, 1'b0);
    endtask

    task automatic expect_outputs(input row_t h, input logic kl, input string what);
        logic         exp_valid;
        ex_redirect_t exp_redir;
        ex_rsp_t      exp_rsp;
        exp_valid        = h.valid && !kl;
        exp_redir.taken  = h.redirect.taken && exp_valid;
        exp_redir.target = h.redirect.target;
        exp_rsp = '{h.result, h.req.rs2_val, h.req.mem_rd, h.req.mem_wr, h.req.mem_width,
                    h.req.rd, h.req.reg_wr, h.req.csr_op, h.req.csr_addr, h.req.ecall,
                    h.req.mret, h.req.error, h.misaligned};
        check_valid(rsp_valid, exp_valid, what);
        check_redirect(redirect, exp_redir, what);
        if (exp_valid) begin
            check_rsp(rsp, exp_rsp, what);
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        row_t held;
        lfsr        = 16'd75;
        table_ready = 1'b0;
        rst         = 1'b1;
        block       = 1'b0;
        // Valid high through reset so only rst can clear the stage
        valid_in    = 1'b1;
        kill        = 1'b0;
        req_in      = '0;
        held        = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        rst      <= 1'b0;
        valid_in <= 1'b0;
        block    <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_valid(rsp_valid, 1'b0, "idle");
        check_redirect(redirect, '0, "idle");
        // Row i is driven while row i-1 is in the stage
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                req_in   <= rows[i].req;
                valid_in <= rows[i].valid;
                block    <= rows[i].block;
            end else begin
                valid_in <= 1'b0;
                block    <= 1'b0;
            end
            kill <= (i > 0) ? rows[i-1].kill : 1'b0;
            @(negedge clk);
            if (i > 0) begin
                if (!rows[i-1].block) begin
                    held = rows[i-1];
                end
                expect_outputs(held, rows[i-1].kill, $sformatf("row %0d", i - 1));
            end
        end
        $display("sim passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + 20) * 8);
        fail_now("timeout: the run did not get through the table in the allowed time");
    end

endmodule

`default_nettype wire

// ==== list.f ====
ex_isa_pkg.sv
ex_bus_pkg.sv
ex_issue_reg.sv
ex_alu.sv
ex_branch_unit.sv
ex_commit_merge.sv
ex_stage.sv
tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_ex_stage -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_stage > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0
